// ==== all.f ====
+incdir+source
source/execPkg.sv
source/aluCore.sv
source/branchUnit.sv
source/issueLane.sv
source/redirectSelect.sv
source/execStage.sv
test/execStage_sva.sv
test/execStageTb.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - include_dirs:
      - source
    files:
      - source/execPkg.sv
      - source/aluCore.sv
      - source/branchUnit.sv
      - source/issueLane.sv
      - source/redirectSelect.sv
      - source/execStage.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/execStage_sva.sv
      - test/execStageTb.sv

// ==== test/execStageTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module execStageTb;
  import execPkg::*;

  localparam int NUM_CYCLES = 3000;
  localparam int RESET_CYCLES = 16;

  logic clk = 1'b0;
  logic rst;
  logic stall;
  xlenT predNextPc, memResult1, memResult2, wbResult1, wbResult2;
  logic valid1, useImm1, jump1, branch1;
  logic valid2, useImm2, jump2, branch2;
  aluOpT aluOp1, aluOp2;
  fwdSelT fwdA1, fwdB1, fwdA2, fwdB2;
  xlenT rs1Data1, rs2Data1, pc1, imm1;
  xlenT rs1Data2, rs2Data2, pc2, imm2;
  logic resultValid1, resultValid2, redirect;
  xlenT result1, writeData1, result2, writeData2, redirectTarget;

  // next values to drive with index 0 for lane 1
  logic   nStall = 1'b0;
  xlenT   nPred = '0;
  xlenT   nMem1 = '0;
  xlenT   nMem2 = '0;
  xlenT   nWb1 = '0;
  xlenT   nWb2 = '0;
  logic   nValid [2] = '{default: 1'b0};
  aluOpT  nOp [2] = '{default: aluAdd};
  fwdSelT nFwdA [2] = '{default: fwdReg};
  fwdSelT nFwdB [2] = '{default: fwdReg};
  logic   nUseImm [2] = '{default: 1'b0};
  logic   nJump [2] = '{default: 1'b0};
  logic   nBranch [2] = '{default: 1'b0};
  xlenT   nRs1 [2] = '{default: '0};
  xlenT   nRs2 [2] = '{default: '0};
  xlenT   nPc [2] = '{default: '0};
  xlenT   nImm [2] = '{default: '0};

  // pend holds what was driven and exp what the output register holds
  bit   pendStall;
  bit   pendValid [2];
  bit   pendRed [2];
  xlenT pendRes [2];
  xlenT pendWd [2];
  xlenT pendTgt [2];
  bit   expValid [2];
  bit   expRed [2];
  xlenT expRes [2];
  xlenT expWd [2];
  xlenT expTgt [2];

  logic [15:0] lfsrState = 16'd20318;
  int checks = 0;
  int valueErrors = 0;
  int otherErrors = 0;
  int squashCount = 0;

  aluOpT opList [25] = '{aluAdd, aluSub, aluSll, aluSrl, aluSra, aluXor, aluOr, aluAnd,
                         aluSlt, aluSltu, aluLui, aluAuipc, aluAddw, aluSubw, aluSllw,
                         aluSrlw, aluSraw, aluJal, aluJalr, aluBeq, aluBne, aluBlt,
                         aluBge, aluBltu, aluBgeu};

  execStage i_dut (.*);

  always #5 clk = ~clk;

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [63:0] takeBits(input int n);
    logic [63:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      bits = {bits[62:0], lfsrState[0]};
    end
    return bits;
  endfunction

  function automatic xlenT drawOperand();
    logic [1:0] mode;
    mode = takeBits(2);
    case (mode)
      2'd0: return takeBits(8); // small positive
      2'd1: return ~xlenT'(takeBits(8)); // small negative
      default: return takeBits(64);
    endcase
  endfunction

  function automatic xlenT aluModel(input aluOpT op, input xlenT a, input xlenT b);
    xlenT res;
    logic [31:0] w;
    res = '0;
    w = 32'd0;
    case (op)
      aluAdd, aluAuipc: res = a + b;
      aluSub:  res = a - b;
      aluSll:  res = a << b[`SHAMT_W-1:0];
      aluSrl:  res = a >> b[`SHAMT_W-1:0];
      aluSra:  res = $signed(a) >>> b[`SHAMT_W-1:0];
      aluXor:  res = a ^ b;
      aluOr:   res = a | b;
      aluAnd:  res = a & b;
      aluSlt:  res = ($signed(a) < $signed(b)) ? xlenT'(1) : '0;
      aluSltu: res = (a < b) ? xlenT'(1) : '0;
      aluLui:  res = b;
      aluAddw: w = a[31:0] + b[31:0];
      aluSubw: w = a[31:0] - b[31:0];
      aluSllw: w = a[31:0] << b[`SHAMT_WORD_W-1:0];
      aluSrlw: w = a[31:0] >> b[`SHAMT_WORD_W-1:0];
      aluSraw: w = $signed(a[31:0]) >>> b[`SHAMT_WORD_W-1:0];
      default: res = '0; // jumps and branches
    endcase
    if (op[5])
      res = {{32{w[31]}}, w};
    return res;
  endfunction

  function automatic xlenT fwdValue(input fwdSelT sel, input xlenT regVal);
    case (sel)
      fwdMem1: return nMem1;
      fwdMem2: return nMem2;
      fwdWb1:  return nWb1;
      fwdWb2:  return nWb2;
      default: return regVal;
    endcase
  endfunction

  function automatic xlenT laneTarget(input int ln);
    xlenT a;
    xlenT b;
    logic cond;
    a = fwdValue(nFwdA[ln], nRs1[ln]);
    b = fwdValue(nFwdB[ln], nRs2[ln]);
    case (nOp[ln])
      aluBeq:  cond = (a == b);
      aluBne:  cond = (a != b);
      aluBlt:  cond = ($signed(a) < $signed(b));
      aluBge:  cond = !($signed(a) < $signed(b));
      aluBltu: cond = (a < b);
      aluBgeu: cond = !(a < b);
      default: cond = 1'b0;
    endcase
    if (nJump[ln])
      return (nOp[ln] == aluJalr) ? a + nImm[ln] : nPc[ln] + nImm[ln];
    else if (nBranch[ln] && cond)
      return nPc[ln] + nImm[ln];
    else
      return nPc[ln] + `INSN_STEP; // fall through
  endfunction

  task automatic drawLane(input int ln);
    int pick;
    logic [11:0] imm12;
    pick = takeBits(5) % 25;
    nValid[ln] = (takeBits(3) != 0); // about 1 in 8 bubbles
    nOp[ln] = opList[pick];
    nFwdA[ln] = fwdSelT'(takeBits(3)); // unused codes too
    nFwdB[ln] = fwdSelT'(takeBits(3));
    nJump[ln] = (nOp[ln] == aluJal) || (nOp[ln] == aluJalr);
    nBranch[ln] = (nOp[ln] >= aluBeq) && (nOp[ln] <= aluBgeu);
    if (nOp[ln] == aluLui || nOp[ln] == aluAuipc)
      nUseImm[ln] = 1'b1;
    else
      nUseImm[ln] = !nBranch[ln] && takeBits(1);
    nRs1[ln] = drawOperand();
    nRs2[ln] = (takeBits(2) == 0) ? nRs1[ln] : drawOperand(); // equal operands for beq/bge
    imm12 = takeBits(12);
    nImm[ln] = (takeBits(2) == 0) ? xlenT'(takeBits(64)) : {{52{imm12[11]}}, imm12};
  endtask

  task automatic laneExpect(input int ln);
    xlenT a;
    xlenT b;
    a = fwdValue(nFwdA[ln], nRs1[ln]);
    b = fwdValue(nFwdB[ln], nRs2[ln]);
    pendValid[ln] = nValid[ln];
    pendWd[ln] = b;
    pendRes[ln] = aluModel(nOp[ln], (nOp[ln] == aluAuipc) ? nPc[ln] : a,
                           nUseImm[ln] ? nImm[ln] : b);
    pendTgt[ln] = laneTarget(ln);
    pendRed[ln] = nValid[ln] && (nJump[ln] || nBranch[ln]) && (nPred != pendTgt[ln]);
  endtask

  task automatic drawCycle();
    nStall = (takeBits(3) == 0);
    nMem1 = takeBits(64);
    nMem2 = takeBits(64);
    nWb1 = takeBits(64);
    nWb2 = takeBits(64);
    nPc[0] = takeBits(64) & ~xlenT'(3);
    nPc[1] = nPc[0] + `INSN_STEP;
    drawLane(0);
    drawLane(1);
    // fetch guessed right or wrong
    case (takeBits(2))
      0: nPred = laneTarget(0);
      1: nPred = laneTarget(1);
      2: nPred = nPc[0] + `INSN_STEP;
      default: nPred = takeBits(64);
    endcase
    laneExpect(0);
    laneExpect(1);
    pendStall = nStall;
  endtask

  task automatic driveInputs();
    stall <= nStall;
    predNextPc <= nPred;
    memResult1 <= nMem1;
    memResult2 <= nMem2;
    wbResult1 <= nWb1;
    wbResult2 <= nWb2;
    valid1 <= nValid[0];
    aluOp1 <= nOp[0];
    fwdA1 <= nFwdA[0];
    fwdB1 <= nFwdB[0];
    useImm1 <= nUseImm[0];
    jump1 <= nJump[0];
    branch1 <= nBranch[0];
    rs1Data1 <= nRs1[0];
    rs2Data1 <= nRs2[0];
    pc1 <= nPc[0];
    imm1 <= nImm[0];
    valid2 <= nValid[1];
    aluOp2 <= nOp[1];
    fwdA2 <= nFwdA[1];
    fwdB2 <= nFwdB[1];
    useImm2 <= nUseImm[1];
    jump2 <= nJump[1];
    branch2 <= nBranch[1];
    rs1Data2 <= nRs1[1];
    rs2Data2 <= nRs2[1];
    pc2 <= nPc[1];
    imm2 <= nImm[1];
  endtask

  task automatic reportValue(input string name, input xlenT expVal, input xlenT actVal);
    $display("Fail %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
    valueErrors++;
  endtask

  task automatic checkOutputs();
    logic expValid2;
    logic expRedirect;
    xlenT expTarget;
    expValid2 = expValid[1] && !expRed[0]; // squashed behind lane 1
    expRedirect = expRed[0] || expRed[1];
    expTarget = expRed[0] ? expTgt[0] : expTgt[1];
    checks++;
    if (resultValid1 !== expValid[0])
      reportValue("resultValid1", expValid[0], resultValid1);
    if (expValid[0] && result1 !== expRes[0])
      reportValue("result1", expRes[0], result1);
    if (expValid[0] && writeData1 !== expWd[0])
      reportValue("writeData1", expWd[0], writeData1);
    if (resultValid2 !== expValid2)
      reportValue("resultValid2", expValid2, resultValid2);
    if (expValid[1] && result2 !== expRes[1])
      reportValue("result2", expRes[1], result2);
    if (expValid[1] && writeData2 !== expWd[1])
      reportValue("writeData2", expWd[1], writeData2);
    if (redirect !== expRedirect)
      reportValue("redirect", expRedirect, redirect);
    if (expRedirect && redirectTarget !== expTarget)
      reportValue("redirectTarget", expTarget, redirectTarget);
    if (expRed[0] && expValid[1])
      squashCount++;
  endtask

  initial begin
    rst = 1'b1;
    drawCycle();
    // valid jumps off the predicted path so that only reset keeps the outputs low
    nStall = 1'b0;
    for (int ln = 0; ln < 2; ln++) begin
      nValid[ln] = 1'b1;
      nOp[ln] = aluJal;
      nJump[ln] = 1'b1;
      nBranch[ln] = 1'b0;
    end
    nPred = ~laneTarget(0);
    laneExpect(0);
    laneExpect(1);
    pendStall = nStall;
    driveInputs();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (resultValid1 !== 1'b0 || resultValid2 !== 1'b0 || redirect !== 1'b0) begin
      $display("outputs were not cleared by reset at %0t", $time);
      otherErrors++;
    end
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge clk);
      // the dut captures what was driven one edge ago unless stalled
      if (!pendStall) begin
        expValid = pendValid;
        expRed = pendRed;
        expRes = pendRes;
        expWd = pendWd;
        expTgt = pendTgt;
      end
      drawCycle();
      driveInputs();
      @(negedge clk);
      checkOutputs();
    end
    if (squashCount == 0) begin
      $display("no cycle had lane 1 redirecting with lane 2 valid");
      otherErrors++;
    end
    $display("checks %0d, value errors %0d, other errors %0d, sva errors %0d, squashes %0d",
             checks, valueErrors, otherErrors, i_dut.i_sva.failCount, squashCount);
    if (valueErrors + otherErrors + i_dut.i_sva.failCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial begin
    #((RESET_CYCLES + NUM_CYCLES + 2) * 10 + 500);
    $display("watchdog expired before the test loop finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/execStage_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module execStageSva (
  input logic          clk,
  input logic          rst,
  input logic          stall,
  input logic          resultValid1,
  input logic          resultValid2,
  input logic          redirect,
  input execPkg::xlenT result1,
  input execPkg::xlenT result2,
  input execPkg::xlenT writeData1,
  input execPkg::xlenT writeData2,
  input execPkg::xlenT redirectTarget,
  input logic          lane1Redirect,
  input execPkg::xlenT lane2Target
);

  int failCount = 0;

  resetClear: assert property (@(posedge clk)
    rst |=> !resultValid1 && !resultValid2 && !redirect)
    else begin
      $error("outputs not low after a reset cycle");
      failCount++;
    end

  // registers hold through a stalled edge
  stallHold: assert property (@(posedge clk) disable iff (rst)
    stall |=> $stable(resultValid1) && $stable(resultValid2) && $stable(redirect) &&
              $stable(result1) && $stable(result2) && $stable(writeData1) &&
              $stable(writeData2) && $stable(redirectTarget))
    else begin
      $error("outputs changed under stall");
      failCount++;
    end

  laneTwoTarget: assert property (@(posedge clk) disable iff (rst)
    redirect && resultValid2 |-> !lane1Redirect && redirectTarget == lane2Target)
    else begin
      $error("lane 2 redirect target not selected while lane 2 valid");
      failCount++;
    end

endmodule

bind execStage execStageSva i_sva (
  .clk            (clk),
  .rst            (rst),
  .stall          (stall),
  .resultValid1   (resultValid1),
  .resultValid2   (resultValid2),
  .redirect       (redirect),
  .result1        (result1),
  .result2        (result2),
  .writeData1     (writeData1),
  .writeData2     (writeData2),
  .redirectTarget (redirectTarget),
  .lane1Redirect  (laneRedirect1),
  .lane2Target    (laneTarget2)
);

`default_nettype wire

// ==== source/execStage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module execStage (
  input  logic            clk,
  input  logic            rst,
  input  logic            stall,
  input  execPkg::xlenT   predNextPc,
  input  execPkg::xlenT   memResult1,
  input  execPkg::xlenT   memResult2,
  input  execPkg::xlenT   wbResult1,
  input  execPkg::xlenT   wbResult2,
  input  logic            valid1,
  input  execPkg::aluOpT  aluOp1,
  input  execPkg::fwdSelT fwdA1,
  input  execPkg::fwdSelT fwdB1,
  input  logic            useImm1,
  input  logic            jump1,
  input  logic            branch1,
  input  execPkg::xlenT   rs1Data1,
  input  execPkg::xlenT   rs2Data1,
  input  execPkg::xlenT   pc1,
  input  execPkg::xlenT   imm1,
  input  logic            valid2,
  input  execPkg::aluOpT  aluOp2,
  input  execPkg::fwdSelT fwdA2,
  input  execPkg::fwdSelT fwdB2,
  input  logic            useImm2,
  input  logic            jump2,
  input  logic            branch2,
  input  execPkg::xlenT   rs1Data2,
  input  execPkg::xlenT   rs2Data2,
  input  execPkg::xlenT   pc2,
  input  execPkg::xlenT   imm2,
  output logic            resultValid1,
  output execPkg::xlenT   result1,
  output execPkg::xlenT   writeData1,
  output logic            resultValid2,
  output execPkg::xlenT   result2,
  output execPkg::xlenT   writeData2,
  output logic            redirect,
  output execPkg::xlenT   redirectTarget
);
  import execPkg::*;

  logic laneValid1;
  logic laneValid2;
  logic laneRedirect1;
  logic laneRedirect2;
  xlenT laneTarget1;
  xlenT laneTarget2;

  // older instruction
  issueLane i_lane1 (
    .clk (clk), .rst (rst), .stall (stall),
    .valid (valid1), .aluOp (aluOp1), .fwdA (fwdA1), .fwdB (fwdB1),
    .useImm (useImm1), .jump (jump1), .branch (branch1),
    .rs1Data (rs1Data1), .rs2Data (rs2Data1), .pc (pc1), .imm (imm1),
    .predNextPc (predNextPc),
    .memResult1 (memResult1), .memResult2 (memResult2),
    .wbResult1 (wbResult1), .wbResult2 (wbResult2),
    .resultValid (laneValid1), .result (result1), .writeData (writeData1),
    .redirect (laneRedirect1), .redirectTarget (laneTarget1)
  );

  // younger instruction, same predicted pc as lane 1
  issueLane i_lane2 (
    .clk (clk), .rst (rst), .stall (stall),
    .valid (valid2), .aluOp (aluOp2), .fwdA (fwdA2), .fwdB (fwdB2),
    .useImm (useImm2), .jump (jump2), .branch (branch2),
    .rs1Data (rs1Data2), .rs2Data (rs2Data2), .pc (pc2), .imm (imm2),
    .predNextPc (predNextPc),
    .memResult1 (memResult1), .memResult2 (memResult2),
    .wbResult1 (wbResult1), .wbResult2 (wbResult2),
    .resultValid (laneValid2), .result (result2), .writeData (writeData2),
    .redirect (laneRedirect2), .redirectTarget (laneTarget2)
  );

  redirectSelect i_redirSel (
    .resultValid1In (laneValid1),
    .redirect1In    (laneRedirect1),
    .target1In      (laneTarget1),
    .resultValid2In (laneValid2),
    .redirect2In    (laneRedirect2),
    .target2In      (laneTarget2),
    .resultValid1   (resultValid1),
    .resultValid2   (resultValid2),
    .redirect       (redirect),
    .redirectTarget (redirectTarget)
  );

endmodule

`default_nettype wire

// ==== source/redirectSelect.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module redirectSelect (
  input  logic          resultValid1In,
  input  logic          redirect1In,
  input  execPkg::xlenT target1In,
  input  logic          resultValid2In,
  input  logic          redirect2In,
  input  execPkg::xlenT target2In,
  output logic          resultValid1,
  output logic          resultValid2,
  output logic          redirect,
  output execPkg::xlenT redirectTarget
);

  // lane 1 is the older instruction
  assign resultValid1 = resultValid1In;

  // lane 2 is on the wrong path once lane 1 redirects
  assign resultValid2 = resultValid2In & ~redirect1In;

  assign redirect = redirect1In | (redirect2In & resultValid2In);

  // lane 1 target wins, lane 2 only when lane 1 stays on path
  assign redirectTarget = redirect1In ? target1In : target2In;

endmodule

`default_nettype wire

// ==== source/issueLane.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module issueLane (
  input  logic            clk,
  input  logic            rst,
  input  logic            stall,
  input  logic            valid,
  input  execPkg::aluOpT  aluOp,
  input  execPkg::fwdSelT fwdA,
  input  execPkg::fwdSelT fwdB,
  input  logic            useImm,
  input  logic            jump,
  input  logic            branch,
  input  execPkg::xlenT   rs1Data,
  input  execPkg::xlenT   rs2Data,
  input  execPkg::xlenT   pc,
  input  execPkg::xlenT   imm,
  input  execPkg::xlenT   predNextPc,
  input  execPkg::xlenT   memResult1,
  input  execPkg::xlenT   memResult2,
  input  execPkg::xlenT   wbResult1,
  input  execPkg::xlenT   wbResult2,
  output logic            resultValid,
  output execPkg::xlenT   result,
  output execPkg::xlenT   writeData,
  output logic            redirect,
  output execPkg::xlenT   redirectTarget
);
  import execPkg::*;

  xlenT rs1Fwd;
  xlenT rs2Fwd;
  xlenT srcA;
  xlenT srcB;
  xlenT aluResult;
  logic laneRedirect;
  xlenT laneTarget;

  function automatic xlenT pickSrc(input fwdSelT sel, input xlenT regVal,
                                   input xlenT mem1, input xlenT mem2,
                                   input xlenT wb1, input xlenT wb2);
    case (sel)
      fwdWb1:  return wb1;
      fwdWb2:  return wb2;
      fwdMem1: return mem1;
      fwdMem2: return mem2;
      default: return regVal; // fwdReg and unused codes
    endcase
  endfunction

  assign rs1Fwd = pickSrc(fwdA, rs1Data, memResult1, memResult2, wbResult1, wbResult2);
  assign rs2Fwd = pickSrc(fwdB, rs2Data, memResult1, memResult2, wbResult1, wbResult2);

  assign srcA = (aluOp == aluAuipc) ? pc : rs1Fwd;
  assign srcB = useImm ? imm : rs2Fwd;

  aluCore i_alu (
    .aluOp  (aluOp),
    .srcA   (srcA),
    .srcB   (srcB),
    .result (aluResult)
  );

  branchUnit i_branch (
    .aluOp      (aluOp),
    .jump       (jump),
    .branch     (branch),
    .pc         (pc),
    .rs1Val     (rs1Fwd), // branches compare forwarded registers
    .rs2Val     (rs2Fwd),
    .imm        (imm),
    .predNextPc (predNextPc),
    .redirect   (laneRedirect),
    .target     (laneTarget)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      resultValid <= 1'b0;
      redirect    <= 1'b0;
    end else if (!stall) begin
      resultValid <= valid;
      redirect    <= valid & laneRedirect; // bubbles never redirect
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      result         <= aluResult;
      writeData      <= rs2Fwd; // store data
      redirectTarget <= laneTarget;
    end
  end

endmodule

`default_nettype wire

// ==== source/branchUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module branchUnit (
  input  execPkg::aluOpT aluOp,
  input  logic           jump,
  input  logic           branch,
  input  execPkg::xlenT  pc,
  input  execPkg::xlenT  rs1Val,
  input  execPkg::xlenT  rs2Val,
  input  execPkg::xlenT  imm,
  input  execPkg::xlenT  predNextPc,
  output logic           redirect,
  output execPkg::xlenT  target
);
  import execPkg::*;

  logic condTrue;
  logic taken;
  xlenT takenTarget;
  xlenT seqPc;

  always_comb begin
    case (aluOp)
      aluBeq:  condTrue = (rs1Val == rs2Val);
      aluBne:  condTrue = (rs1Val != rs2Val);
      aluBlt:  condTrue = ($signed(rs1Val) < $signed(rs2Val));
      aluBge:  condTrue = ($signed(rs1Val) >= $signed(rs2Val));
      aluBltu: condTrue = (rs1Val < rs2Val);
      aluBgeu: condTrue = (rs1Val >= rs2Val);
      default: condTrue = 1'b0;
    endcase
  end

  assign takenTarget = (aluOp == aluJalr) ? rs1Val + imm : pc + imm; // jalr is register based
  assign seqPc = pc + xlenT'(`INSN_STEP);
  assign taken = jump | (branch & condTrue);

  // not-taken branch falls through to the next instruction
  assign target = taken ? takenTarget : seqPc;

  // only redirect when fetch followed a different path
  assign redirect = (taken | branch) & (predNextPc != target);

endmodule

`default_nettype wire

// ==== source/aluCore.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module aluCore (
  input  execPkg::aluOpT aluOp,
  input  execPkg::xlenT  srcA,
  input  execPkg::xlenT  srcB,
  output execPkg::xlenT  result
);
  import execPkg::*;

  logic signed [`XLEN-1:0] srcASigned;
  logic signed [`XLEN-1:0] srcBSigned;
  logic [31:0] wordA;
  logic [31:0] wordB;
  logic [31:0] wordRes;
  logic [`SHAMT_W-1:0] shamt;
  logic [`SHAMT_WORD_W-1:0] shamtWord;

  assign srcASigned = srcA;
  assign srcBSigned = srcB;
  assign wordA = srcA[31:0];
  assign wordB = srcB[31:0];
  assign shamt = srcB[`SHAMT_W-1:0];
  assign shamtWord = srcB[`SHAMT_WORD_W-1:0];

  // 32-bit datapath for the w forms
  always_comb begin
    case (aluOp)
      aluSllw: wordRes = wordA << shamtWord;
      aluSrlw: wordRes = wordA >> shamtWord; // zero fill at bit 31
      aluSraw: wordRes = $signed(wordA) >>> shamtWord;
      aluAddw: wordRes = wordA + wordB;
      aluSubw: wordRes = wordA - wordB;
      default: wordRes = '0;
    endcase
  end

  always_comb begin
    case (aluOp)
      aluSll:  result = srcA << shamt;
      aluSrl:  result = srcA >> shamt;
      aluSra:  result = srcASigned >>> shamt;
      aluAdd:  result = srcA + srcB;
      aluSub:  result = srcA - srcB;
      aluXor:  result = srcA ^ srcB;
      aluOr:   result = srcA | srcB;
      aluAnd:  result = srcA & srcB;
      aluSlt:  result = {{(`XLEN-1){1'b0}}, srcASigned < srcBSigned};
      aluSltu: result = {{(`XLEN-1){1'b0}}, srcA < srcB};
      aluAuipc: result = srcA + srcB; // srcA already holds pc
      aluLui:  result = srcB;
      aluSllw,
      aluSrlw,
      aluSraw,
      aluAddw,
      aluSubw: result = {{(`XLEN-32){wordRes[31]}}, wordRes}; // sign extend
      // control transfers and unknown codes leave the result at zero
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/execPkg.sv ====
`default_nettype none

`include "exec_cfg.svh"

package execPkg;

  typedef logic [`XLEN-1:0] xlenT; // data and pc word

  // low five bits follow the decoder numbering
  // bit 5 set for the 32-bit word forms
  typedef enum logic [5:0] {
    aluSll  = 6'd1,
    aluSrl  = 6'd2,
    aluSra  = 6'd3,
    aluAdd  = 6'd4, // also load/store address
    aluSub  = 6'd5,
    aluXor  = 6'd14,
    aluOr   = 6'd15,
    aluAnd  = 6'd16,
    aluSlt  = 6'd17,
    aluSltu = 6'd18,
    aluAuipc = 6'd19,
    aluLui  = 6'd20,
    aluJalr = 6'd21,
    aluJal  = 6'd22,
    aluBeq  = 6'd23,
    aluBne  = 6'd24,
    aluBlt  = 6'd25,
    aluBge  = 6'd26,
    aluBltu = 6'd27,
    aluBgeu = 6'd28,
    aluSllw = 6'd33,
    aluSrlw = 6'd34,
    aluSraw = 6'd35,
    aluAddw = 6'd36,
    aluSubw = 6'd37
  } aluOpT;

  // operand source, unlisted codes fall back to the register file
  typedef enum logic [2:0] {
    fwdReg  = 3'b000,
    fwdWb1  = 3'b001,
    fwdMem1 = 3'b010,
    fwdWb2  = 3'b101,
    fwdMem2 = 3'b110
  } fwdSelT;

endpackage

`default_nettype wire

// ==== source/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data and pc width
`define XLEN 64

// pc increment of a sequential instruction
`define INSN_STEP 4

// shift amount widths
`define SHAMT_W 6
`define SHAMT_WORD_W 5

`endif
